// File: source/synthPkg.sv
`default_nettype none

package synthPkg;

	// Voice count, one per note key A to G
	localparam int NOTE_COUNT = 7;

	// Voice number, 0 to 6 for A to G
	typedef logic [2:0] noteIndex_t;

	// One bit per voice, bit i is note i
	typedef logic [NOTE_COUNT-1:0] noteMask_t;

	// Signed octave shift, -4 to +4
	typedef logic signed [3:0] octave_t;

	// Half-period in clock cycles
	typedef logic [19:0] halfPeriod_t;

	// Signed audio sample
	typedef logic signed [31:0] sample_t;

	// PS/2 set 2 make codes, A first
	localparam logic [7:0] NOTE_SCAN_CODES [NOTE_COUNT] = '{
		8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D
	};

	// Prefix bytes
	localparam logic [7:0] BREAK_PREFIX = 8'hF0;
	localparam logic [7:0] EXTEND_PREFIX = 8'hE0;

	// Extended arrow codes
	localparam logic [7:0] UP_CODE = 8'h75;
	localparam logic [7:0] DOWN_CODE = 8'h72;
	localparam logic [7:0] LEFT_CODE = 8'h6B;
	localparam logic [7:0] RIGHT_CODE = 8'h74;

	// 25e6 / note frequency at octave 0, truncated
	// A 440, B 494, C 523, D 587, E 659, F 698, G 784 Hz
	localparam halfPeriod_t BASE_HALF_PERIODS [NOTE_COUNT] = '{
		20'd56818, 20'd50607, 20'd47801, 20'd42589, 20'd37936, 20'd35816, 20'd31887
	};

	// Q14 half-period multipliers
	// Flat lengthens by one semitone, sharp shortens by one
	localparam logic [14:0] FLAT_FACTOR = 15'd17359;
	localparam logic [14:0] SHARP_FACTOR = 15'd15465;

	// Level magnitude of one sounding voice
	localparam sample_t VOICE_AMPLITUDE = 32'sd10000000;

endpackage

`default_nettype wire

// File: source/keyDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module keyDecoder (
	input  wire                    CLOCK_50,
	input  wire                    reset,
	input  wire [7:0]              scanCode,
	input  wire                    scanValid,
	output logic                   scanReady,
	output synthPkg::noteMask_t    noteOn,
	output synthPkg::octave_t      octave,
	output logic                   flat,
	output logic                   sharp,
	output logic                   pitchRequest,
	output synthPkg::noteIndex_t   requestNote
);

	// Prefix FSM encoding
	// Break state also covers E0 F0
	localparam logic [1:0] PREFIX_PLAIN = 2'd0;
	localparam logic [1:0] PREFIX_BREAK = 2'd1;
	localparam logic [1:0] PREFIX_EXTEND = 2'd2;

	// Octave clamp limits
	localparam synthPkg::octave_t OCTAVE_MAX = 4'sd4;
	localparam synthPkg::octave_t OCTAVE_MIN = -4'sd4;

	logic [1:0] prefixState;
	logic byteAccepted;
	logic noteHit;
	synthPkg::noteIndex_t noteCode;

	assign byteAccepted = scanValid && scanReady;

	// Match the byte against the seven note keys
	always_comb begin
		noteHit = 1'b0;
		noteCode = '0;
		for (int i = 0; i < synthPkg::NOTE_COUNT; i++) begin
			if (scanCode == synthPkg::NOTE_SCAN_CODES[i]) begin
				noteHit = 1'b1;
				noteCode = synthPkg::noteIndex_t'(i);
			end
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			prefixState <= PREFIX_PLAIN;
			noteOn <= '0;
			octave <= '0;
			flat <= 1'b0;
			sharp <= 1'b0;
			pitchRequest <= 1'b0;
			scanReady <= 1'b0;
		end else begin
			// Ready every cycle once out of reset
			scanReady <= 1'b1;
			// One-cycle strobe
			pitchRequest <= 1'b0;
			if (byteAccepted) begin
				case (prefixState)
					PREFIX_PLAIN: begin
						if (scanCode == synthPkg::BREAK_PREFIX) begin
							prefixState <= PREFIX_BREAK;
						end else if (scanCode == synthPkg::EXTEND_PREFIX) begin
							prefixState <= PREFIX_EXTEND;
						end else if (noteHit) begin
							// Note press, voice on and new pitch
							noteOn[noteCode] <= 1'b1;
							pitchRequest <= 1'b1;
						end else begin
							// Any other key silences everything
							noteOn <= '0;
						end
					end
					PREFIX_EXTEND: begin
						prefixState <= PREFIX_PLAIN;
						case (scanCode)
							// E0 F0 starts an extended release
							synthPkg::BREAK_PREFIX: prefixState <= PREFIX_BREAK;
							synthPkg::EXTEND_PREFIX: prefixState <= PREFIX_EXTEND;
							synthPkg::UP_CODE: begin
								if (octave != OCTAVE_MAX) begin
									octave <= octave + 4'sd1;
								end
							end
							synthPkg::DOWN_CODE: begin
								if (octave != OCTAVE_MIN) begin
									octave <= octave - 4'sd1;
								end
							end
							synthPkg::LEFT_CODE: flat <= ~flat;
							synthPkg::RIGHT_CODE: sharp <= ~sharp;
							default: ;
						endcase
					end
					default: begin
						// Release byte, only note keys matter
						prefixState <= PREFIX_PLAIN;
						if (noteHit) begin
							noteOn[noteCode] <= 1'b0;
						end
					end
				endcase
			end
		end
	end

	// Note number rides along with the strobe
	always_ff @(posedge CLOCK_50) begin
		if (byteAccepted && noteHit) begin
			requestNote <= noteCode;
		end
	end

endmodule

`default_nettype wire

// File: source/pitchScaler.sv
`timescale 1ns/10ps
`default_nettype none

module pitchScaler (
	input  wire                     CLOCK_50,
	input  wire                     reset,
	input  wire                     pitchRequest,
	input  wire synthPkg::noteIndex_t requestNote,
	input  wire synthPkg::octave_t  octave,
	input  wire                     flat,
	input  wire                     sharp,
	output logic                    loadValid,
	output synthPkg::noteIndex_t    loadNote,
	output synthPkg::halfPeriod_t   loadHalfPeriod
);

	synthPkg::octave_t negOctave;
	logic [2:0] shiftAmount;
	synthPkg::halfPeriod_t baseValue;
	synthPkg::halfPeriod_t shiftedValue;

	logic stageValid;
	synthPkg::noteIndex_t stageNote;
	synthPkg::halfPeriod_t stageValue;
	logic stageFlat;
	logic stageSharp;

	logic [34:0] product;
	synthPkg::halfPeriod_t scaledValue;

	// Stage one, table lookup and octave shift
	// Higher octave means shorter half-period
	assign negOctave = -octave;
	assign shiftAmount = octave[3] ? negOctave[2:0] : octave[2:0];
	assign baseValue = synthPkg::BASE_HALF_PERIODS[requestNote];
	assign shiftedValue = octave[3] ? (baseValue << shiftAmount) : (baseValue >> shiftAmount);

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			stageValid <= 1'b0;
		end else begin
			stageValid <= pitchRequest;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		stageNote <= requestNote;
		stageValue <= shiftedValue;
		stageFlat <= flat;
		stageSharp <= sharp;
	end

	// Stage two, Q14 semitone scaling
	// Sharp has priority over flat
	assign product = stageValue * (stageSharp ? synthPkg::SHARP_FACTOR : synthPkg::FLAT_FACTOR);
	assign scaledValue = (stageSharp || stageFlat) ? product[33:14] : stageValue;

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			loadValid <= 1'b0;
		end else begin
			loadValid <= stageValid;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		loadNote <= stageNote;
		loadHalfPeriod <= scaledValue;
	end

endmodule

`default_nettype wire

// File: source/toneGenerator.sv
`timescale 1ns/10ps
`default_nettype none

module toneGenerator #(
	parameter int NOTE_INDEX = 0
) (
	input  wire                       CLOCK_50,
	input  wire                       reset,
	input  wire                       loadValid,
	input  wire synthPkg::noteIndex_t loadNote,
	input  wire synthPkg::halfPeriod_t loadHalfPeriod,
	input  wire                       noteOn,
	output synthPkg::sample_t         level
);

	// This voice's number on the load bus
	localparam synthPkg::noteIndex_t VOICE_NOTE = synthPkg::noteIndex_t'(NOTE_INDEX);

	synthPkg::halfPeriod_t halfPeriod;
	synthPkg::halfPeriod_t counter;
	logic phase;

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			// Start at the octave 0 pitch
			halfPeriod <= synthPkg::BASE_HALF_PERIODS[NOTE_INDEX];
			counter <= '0;
			phase <= 1'b1;
		end else if (loadValid && (loadNote == VOICE_NOTE)) begin
			// New pitch restarts the wave on the positive half
			halfPeriod <= loadHalfPeriod;
			counter <= '0;
			phase <= 1'b1;
		end else if (counter == halfPeriod) begin
			// Half-period done, halfPeriod+1 cycles per level
			counter <= '0;
			phase <= ~phase;
		end else begin
			counter <= counter + 1'b1;
		end
	end

	// Square level, silent when the key is up
	always_ff @(posedge CLOCK_50) begin
		if (!noteOn) begin
			level <= '0;
		end else if (phase) begin
			level <= synthPkg::VOICE_AMPLITUDE;
		end else begin
			level <= -synthPkg::VOICE_AMPLITUDE;
		end
	end

endmodule

`default_nettype wire

// File: source/sampleMixer.sv
`timescale 1ns/10ps
`default_nettype none

module sampleMixer #(
	parameter int SAMPLE_DIVIDER = 1042
) (
	input  wire                    CLOCK_50,
	input  wire                    reset,
	input  wire synthPkg::sample_t levels [synthPkg::NOTE_COUNT],
	output synthPkg::sample_t      sample,
	output logic                   sampleValid,
	input  wire                    sampleReady
);

	// At least one bit even for a divider of 1
	localparam int DIV_WIDTH = (SAMPLE_DIVIDER > 1) ? $clog2(SAMPLE_DIVIDER) : 1;
	localparam logic [DIV_WIDTH-1:0] DIV_LAST = DIV_WIDTH'(SAMPLE_DIVIDER - 1);

	synthPkg::sample_t levelSum;
	synthPkg::sample_t mixSum;
	logic [DIV_WIDTH-1:0] divCount;
	logic tick;

	// Wrap-around sum of all voices
	always_comb begin
		levelSum = '0;
		for (int i = 0; i < synthPkg::NOTE_COUNT; i++) begin
			levelSum = levelSum + levels[i];
		end
	end

	always_ff @(posedge CLOCK_50) begin
		mixSum <= levelSum;
	end

	// Sample-rate divider
	assign tick = (divCount == DIV_LAST);

	always_ff @(posedge CLOCK_50) begin
		if (reset || tick) begin
			divCount <= '0;
		end else begin
			divCount <= divCount + 1'b1;
		end
	end

	// Output register, frozen while a sample waits for ready
	// Ticks during a stall are lost
	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			sampleValid <= 1'b0;
		end else if (!sampleValid || sampleReady) begin
			sampleValid <= tick;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if ((!sampleValid || sampleReady) && tick) begin
			sample <= mixSum;
		end
	end

endmodule

`default_nettype wire

// File: source/synthTop.sv
`timescale 1ns/10ps
`default_nettype none

module synthTop #(
	parameter int SAMPLE_DIVIDER = 1042
) (
	input  wire                  CLOCK_50,
	input  wire                  reset,
	// Scan-code byte stream
	input  wire [7:0]            scanCode,
	input  wire                  scanValid,
	output logic                 scanReady,
	// Audio sample stream
	output synthPkg::sample_t    sample,
	output logic                 sampleValid,
	input  wire                  sampleReady,
	// Status
	output synthPkg::noteMask_t  noteOn,
	output synthPkg::octave_t    octave,
	output logic                 flat,
	output logic                 sharp
);

	// Decoder to pitch pipeline
	logic pitchRequest;
	synthPkg::noteIndex_t requestNote;

	// Pitch pipeline to voices
	logic loadValid;
	synthPkg::noteIndex_t loadNote;
	synthPkg::halfPeriod_t loadHalfPeriod;

	// Voice levels into the mixer
	synthPkg::sample_t levels [synthPkg::NOTE_COUNT];

	keyDecoder keyDecoder_i (
		.CLOCK_50     (CLOCK_50),
		.reset        (reset),
		.scanCode     (scanCode),
		.scanValid    (scanValid),
		.scanReady    (scanReady),
		.noteOn       (noteOn),
		.octave       (octave),
		.flat         (flat),
		.sharp        (sharp),
		.pitchRequest (pitchRequest),
		.requestNote  (requestNote)
	);

	pitchScaler pitchScaler_i (
		.CLOCK_50       (CLOCK_50),
		.reset          (reset),
		.pitchRequest   (pitchRequest),
		.requestNote    (requestNote),
		.octave         (octave),
		.flat           (flat),
		.sharp          (sharp),
		.loadValid      (loadValid),
		.loadNote       (loadNote),
		.loadHalfPeriod (loadHalfPeriod)
	);

	// One voice per note, load bus shared by all
	for (genvar i = 0; i < synthPkg::NOTE_COUNT; i++) begin : voice
		toneGenerator #(
			.NOTE_INDEX (i)
		) toneGenerator_i (
			.CLOCK_50       (CLOCK_50),
			.reset          (reset),
			.loadValid      (loadValid),
			.loadNote       (loadNote),
			.loadHalfPeriod (loadHalfPeriod),
			.noteOn         (noteOn[i]),
			.level          (levels[i])
		);
	end

	sampleMixer #(
		.SAMPLE_DIVIDER (SAMPLE_DIVIDER)
	) sampleMixer_i (
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.levels      (levels),
		.sample      (sample),
		.sampleValid (sampleValid),
		.sampleReady (sampleReady)
	);

endmodule

`default_nettype wire

// File: bench/synthTbTasks.svh
`ifndef SYNTH_TB_TASKS_SVH
`define SYNTH_TB_TASKS_SVH

// Typed compares for each result kind
task automatic compareMask(input string name, input synthPkg::noteMask_t got,
		input synthPkg::noteMask_t expected);
	if (got !== expected) begin
		errorCount++;
		$display("ERR %s got %h expected %h", name, got, expected);
	end
endtask

task automatic compareOctave(input string name, input synthPkg::octave_t got,
		input synthPkg::octave_t expected);
	if (got !== expected) begin
		errorCount++;
		$display("ERR %s got %h expected %h", name, got, expected);
	end
endtask

task automatic compareBit(input string name, input logic got, input logic expected);
	if (got !== expected) begin
		errorCount++;
		$display("ERR %s got %h expected %h", name, got, expected);
	end
endtask

task automatic compareSample(input string name, input synthPkg::sample_t got,
		input synthPkg::sample_t expected);
	if (got !== expected) begin
		errorCount++;
		$display("ERR %s got %h expected %h", name, got, expected);
	end
endtask

task automatic compareHalfPeriod(input string name, input synthPkg::halfPeriod_t got,
		input synthPkg::halfPeriod_t expected);
	if (got !== expected) begin
		errorCount++;
		$display("ERR %s got %h expected %h", name, got, expected);
	end
endtask

// One line per finished test
task automatic finishTest(input string name, input int startErrors);
	testCount++;
	if (errorCount == startErrors) begin
		$display("PASS %s", name);
	end else begin
		failedCount++;
		$display("FAIL %s with %0d errors", name, errorCount - startErrors);
	end
endtask

// One byte over valid/ready
// Returns at the negedge after acceptance
task automatic sendByte(input logic [7:0] code);
	int waitCount;
	waitCount = 0;
	@(negedge CLOCK_50);
	while (!scanReady && waitCount < READY_WAIT) begin
		@(negedge CLOCK_50);
		waitCount++;
	end
	if (!scanReady) begin
		errorCount++;
		$display("Timeout, scanReady stayed low");
	end
	@(posedge CLOCK_50);
	scanCode <= code;
	scanValid <= 1'b1;
	// Taken on this edge
	@(posedge CLOCK_50);
	scanValid <= 1'b0;
	@(negedge CLOCK_50);
endtask

task automatic sendRelease(input logic [7:0] code);
	sendByte(synthPkg::BREAK_PREFIX);
	sendByte(code);
endtask

task automatic sendExtended(input logic [7:0] code);
	sendByte(synthPkg::EXTEND_PREFIX);
	sendByte(code);
endtask

task automatic sendExtendedRelease(input logic [7:0] code);
	sendByte(synthPkg::EXTEND_PREFIX);
	sendRelease(code);
endtask

task automatic randomNote(output synthPkg::noteIndex_t note);
	logic [31:0] bits;
	randomBits(3, bits);
	// Only seven voices so 7 folds onto A
	note = (bits[2:0] == 3'd7) ? 3'd0 : bits[2:0];
endtask

// Plain make code that is neither a note nor a prefix
task automatic randomOtherCode(output logic [7:0] code);
	logic [31:0] bits;
	logic clash;
	code = 8'h1C;
	for (int tries = 0; tries < 16; tries++) begin
		randomBits(8, bits);
		clash = (bits[7:0] == synthPkg::BREAK_PREFIX) || (bits[7:0] == synthPkg::EXTEND_PREFIX);
		for (int i = 0; i < synthPkg::NOTE_COUNT; i++) begin
			if (bits[7:0] == synthPkg::NOTE_SCAN_CODES[i]) begin
				clash = 1'b1;
			end
		end
		if (!clash) begin
			code = bits[7:0];
			break;
		end
	end
endtask

// Ready held high so every negedge with valid is one transfer
task automatic nextSample(output synthPkg::sample_t value);
	int waitCount;
	waitCount = 0;
	@(negedge CLOCK_50);
	while (!sampleValid && waitCount < SAMPLE_WAIT) begin
		@(negedge CLOCK_50);
		waitCount++;
	end
	if (sampleValid) begin
		value = sample;
	end else begin
		errorCount++;
		$display("Timeout, sampleValid stayed low");
		value = 'x;
	end
endtask

// Counts samples equal to value
// Leaves the next run's first sample in value
task automatic measureRun(inout synthPkg::sample_t value, output int length);
	synthPkg::sample_t current;
	current = value;
	length = 1;
	nextSample(value);
	while (value == current && length < RUN_LIMIT) begin
		length++;
		nextSample(value);
	end
	if (length >= RUN_LIMIT) begin
		errorCount++;
		$display("Timeout, voice level never changed");
	end
endtask

// Half-period from the shift and Q14 rules
function automatic synthPkg::halfPeriod_t scaledHalfPeriod(input synthPkg::noteIndex_t note,
		input int shift, input logic isFlat, input logic isSharp);
	longint value;
	value = synthPkg::BASE_HALF_PERIODS[note];
	if (shift >= 0) begin
		value = value >> shift;
	end else begin
		value = value << (-shift);
	end
	// Sharp beats flat
	if (isSharp) begin
		value = (value * synthPkg::SHARP_FACTOR) / 16384;
	end else if (isFlat) begin
		value = (value * synthPkg::FLAT_FACTOR) / 16384;
	end
	return synthPkg::halfPeriod_t'(value);
endfunction

// Measures full runs after the load between key press and release
task automatic playNote(input synthPkg::noteIndex_t note, input int runs,
		input synthPkg::halfPeriod_t expected);
	synthPkg::sample_t value;
	synthPkg::sample_t expectedLevel;
	int length;
	int waitCount;
	sendByte(synthPkg::NOTE_SCAN_CODES[note]);
	waitCount = 0;
	nextSample(value);
	while (value == 0 && waitCount < START_WAIT) begin
		nextSample(value);
		waitCount++;
	end
	if (value == 0) begin
		errorCount++;
		$display("Voice stayed silent after the key press");
	end
	// Up to two runs straddle the load
	measureRun(value, length);
	measureRun(value, length);
	expectedLevel = (value > 0) ? synthPkg::VOICE_AMPLITUDE : -synthPkg::VOICE_AMPLITUDE;
	for (int run = 0; run < runs; run++) begin
		compareSample("sample", value, expectedLevel);
		measureRun(value, length);
		compareHalfPeriod("halfPeriod", synthPkg::halfPeriod_t'(length - 1), expected);
		expectedLevel = -expectedLevel;
	end
	sendRelease(synthPkg::NOTE_SCAN_CODES[note]);
endtask

task automatic testNoteOnOff();
	int startErrors;
	synthPkg::noteMask_t expected;
	synthPkg::noteIndex_t note;
	logic [31:0] pick;
	logic [7:0] other;
	startErrors = errorCount;
	expected = '0;
	for (int step = 0; step < 12; step++) begin
		randomNote(note);
		randomBits(1, pick);
		if (pick[0]) begin
			sendByte(synthPkg::NOTE_SCAN_CODES[note]);
			expected[note] = 1'b1;
		end else begin
			// F0 alone changes nothing
			sendByte(synthPkg::BREAK_PREFIX);
			compareMask("noteOn", noteOn, expected);
			sendByte(synthPkg::NOTE_SCAN_CODES[note]);
			expected[note] = 1'b0;
		end
		compareMask("noteOn", noteOn, expected);
	end
	// Hold one note so the silencing shows
	randomNote(note);
	sendByte(synthPkg::NOTE_SCAN_CODES[note]);
	expected[note] = 1'b1;
	compareMask("noteOn", noteOn, expected);
	randomOtherCode(other);
	sendByte(other);
	compareMask("noteOn", noteOn, '0);
	finishTest("noteOnOff", startErrors);
endtask

task automatic testStatus();
	int startErrors;
	synthPkg::octave_t expected;
	synthPkg::noteIndex_t note;
	synthPkg::noteMask_t held;
	startErrors = errorCount;
	expected = '0;
	// Up past the top, down past the bottom, back to 0
	for (int step = 0; step < 6; step++) begin
		sendExtended(synthPkg::UP_CODE);
		if (expected != 4'sd4) begin
			expected = expected + 4'sd1;
		end
		compareOctave("octave", octave, expected);
	end
	for (int step = 0; step < 10; step++) begin
		sendExtended(synthPkg::DOWN_CODE);
		if (expected != -4'sd4) begin
			expected = expected - 4'sd1;
		end
		compareOctave("octave", octave, expected);
	end
	for (int step = 0; step < 4; step++) begin
		sendExtended(synthPkg::UP_CODE);
		expected = expected + 4'sd1;
		compareOctave("octave", octave, expected);
	end
	sendExtended(synthPkg::LEFT_CODE);
	compareBit("flat", flat, 1'b1);
	compareBit("sharp", sharp, 1'b0);
	sendExtended(synthPkg::RIGHT_CODE);
	compareBit("sharp", sharp, 1'b1);
	// A held note must survive the extended releases
	randomNote(note);
	held = '0;
	held[note] = 1'b1;
	sendByte(synthPkg::NOTE_SCAN_CODES[note]);
	// Extended releases are ignored
	sendExtendedRelease(synthPkg::UP_CODE);
	sendExtendedRelease(synthPkg::LEFT_CODE);
	sendExtendedRelease(synthPkg::RIGHT_CODE);
	compareOctave("octave", octave, 4'sd0);
	compareBit("flat", flat, 1'b1);
	compareBit("sharp", sharp, 1'b1);
	compareMask("noteOn", noteOn, held);
	sendRelease(synthPkg::NOTE_SCAN_CODES[note]);
	compareMask("noteOn", noteOn, '0);
	sendExtended(synthPkg::LEFT_CODE);
	sendExtended(synthPkg::RIGHT_CODE);
	compareBit("flat", flat, 1'b0);
	compareBit("sharp", sharp, 1'b0);
	finishTest("status", startErrors);
endtask

task automatic testWaveform();
	int startErrors;
	synthPkg::noteIndex_t note;
	startErrors = errorCount;
	randomNote(note);
	playNote(note, 2, synthPkg::BASE_HALF_PERIODS[note]);
	finishTest("waveform", startErrors);
endtask

task automatic testPitchScaling();
	int startErrors;
	synthPkg::noteIndex_t note;
	startErrors = errorCount;
	randomNote(note);
	// Octave +2
	sendExtended(synthPkg::UP_CODE);
	sendExtended(synthPkg::UP_CODE);
	playNote(note, 1, scaledHalfPeriod(note, 2, 1'b0, 1'b0));
	// Octave -1 and flat
	repeat (3) sendExtended(synthPkg::DOWN_CODE);
	sendExtended(synthPkg::LEFT_CODE);
	playNote(note, 1, scaledHalfPeriod(note, -1, 1'b1, 1'b0));
	// Octave 0 with flat and sharp together
	sendExtended(synthPkg::UP_CODE);
	sendExtended(synthPkg::RIGHT_CODE);
	playNote(note, 1, scaledHalfPeriod(note, 0, 1'b1, 1'b1));
	sendExtended(synthPkg::LEFT_CODE);
	sendExtended(synthPkg::RIGHT_CODE);
	finishTest("pitchScaling", startErrors);
endtask

task automatic testMixing();
	int startErrors;
	synthPkg::sample_t value;
	synthPkg::sample_t held;
	synthPkg::sample_t expected;
	synthPkg::noteIndex_t first;
	synthPkg::noteIndex_t second;
	logic [7:0] other;
	startErrors = errorCount;
	// Silence
	for (int i = 0; i < 32; i++) begin
		nextSample(value);
		compareSample("sample", value, 32'sd0);
	end
	randomNote(first);
	randomNote(second);
	if (second == first) begin
		second = (first == 3'd6) ? 3'd0 : first + 3'd1;
	end
	sendByte(synthPkg::NOTE_SCAN_CODES[first]);
	sendByte(synthPkg::NOTE_SCAN_CODES[second]);
	// Let the second voice load
	repeat (8) nextSample(value);
	// Two voices sum to -2A, 0 or +2A
	for (int i = 0; i < 120000; i++) begin
		nextSample(value);
		if (value > synthPkg::VOICE_AMPLITUDE) begin
			expected = 2 * synthPkg::VOICE_AMPLITUDE;
		end else if (value < -synthPkg::VOICE_AMPLITUDE) begin
			expected = -2 * synthPkg::VOICE_AMPLITUDE;
		end else begin
			expected = 32'sd0;
		end
		compareSample("sample", value, expected);
	end
	// Stall the sink
	@(posedge CLOCK_50);
	sampleReady <= 1'b0;
	@(negedge CLOCK_50);
	held = sample;
	// Long enough for the faster voice to flip twice
	for (int i = 0; i < 120000; i++) begin
		@(negedge CLOCK_50);
		compareBit("sampleValid", sampleValid, 1'b1);
		compareSample("sample", sample, held);
	end
	@(posedge CLOCK_50);
	sampleReady <= 1'b1;
	nextSample(value);
	randomOtherCode(other);
	sendByte(other);
	compareMask("noteOn", noteOn, '0);
	finishTest("mixing", startErrors);
endtask

`endif

// File: bench/synthTb.sv
`timescale 1ns/10ps
`default_nettype none

module synthTb;

	// Wait limits in clock cycles or samples
	localparam int READY_WAIT = 100;
	localparam int SAMPLE_WAIT = 16;
	localparam int START_WAIT = 100;
	localparam int RUN_LIMIT = 1 << 21;

	logic CLOCK_50;
	logic reset;
	logic [7:0] scanCode;
	logic scanValid;
	logic scanReady;
	synthPkg::sample_t sample;
	logic sampleValid;
	logic sampleReady;
	synthPkg::noteMask_t noteOn;
	synthPkg::octave_t octave;
	logic flat;
	logic sharp;

	// Run bookkeeping
	int errorCount;
	int testCount;
	int failedCount;

	// Random source state
	logic [31:0] lfsrState;

	// Sim clock with a 10 ns period
	always #5 CLOCK_50 = ~CLOCK_50;

	// Divider of 1 gives one sample per cycle
	synthTop #(
		.SAMPLE_DIVIDER (1)
	) synthTop_i (
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.scanCode    (scanCode),
		.scanValid   (scanValid),
		.scanReady   (scanReady),
		.sample      (sample),
		.sampleValid (sampleValid),
		.sampleReady (sampleReady),
		.noteOn      (noteOn),
		.octave      (octave),
		.flat        (flat),
		.sharp       (sharp)
	);

	// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic randomBits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
	endtask

	`include "synthTbTasks.svh"

	initial begin
		CLOCK_50 = 1'b0;
		reset = 1'b1;
		scanCode = 8'h00;
		scanValid = 1'b0;
		sampleReady = 1'b1;
		errorCount = 0;
		testCount = 0;
		failedCount = 0;
		lfsrState = 32'h9468;
		// Ten cycles of reset
		repeat (9) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		// No byte is taken during reset
		compareBit("scanReady", scanReady, 1'b0);
		@(posedge CLOCK_50);
		reset <= 1'b0;

		testNoteOnOff();
		testStatus();
		testWaveform();
		testPitchScaling();
		testMixing();

		$display("Tests run %0d, tests failed %0d, errors %0d", testCount, failedCount,
			errorCount);
		if (errorCount == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+bench
source/synthPkg.sv
source/keyDecoder.sv
source/pitchScaler.sv
source/toneGenerator.sv
source/sampleMixer.sv
source/synthTop.sv
bench/synthTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module synthTb -f all.f -o synthSim
./obj_dir/synthSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
	exit 0
else
	exit 1
fi
